/* rtl/rv_decode_pkg.sv */
// RV32I decode definitions
package rv_decode_pkg;

    // field widths
    localparam int XLEN     = 32;
    localparam int OPCODE_W = 7;
    localparam int REG_W    = 5;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int SHAMT_W  = 5;
    localparam int FMT_W    = 3;
    localparam int CLS_W    = 4;

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [REG_W-1:0]    reg_idx_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;
    typedef logic [SHAMT_W-1:0]  shamt_t;
    typedef logic [FMT_W-1:0]    imm_fmt_t;
    typedef logic [CLS_W-1:0]    op_class_t;

    // major opcodes, instr[6:0]
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    // funct7 values allowed on shifts and OP
    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // immediate formats, NONE gives a zero immediate
    localparam imm_fmt_t FMT_NONE = 3'd0;
    localparam imm_fmt_t FMT_I    = 3'd1;
    localparam imm_fmt_t FMT_S    = 3'd2;
    localparam imm_fmt_t FMT_B    = 3'd3;
    localparam imm_fmt_t FMT_U    = 3'd4;
    localparam imm_fmt_t FMT_J    = 3'd5;

    // operation classes
    localparam op_class_t CLS_ILLEGAL   = 4'd0;
    localparam op_class_t CLS_LUI       = 4'd1;
    localparam op_class_t CLS_AUIPC     = 4'd2;
    localparam op_class_t CLS_JAL       = 4'd3;
    localparam op_class_t CLS_JALR      = 4'd4;
    localparam op_class_t CLS_BRANCH    = 4'd5;
    localparam op_class_t CLS_LOAD      = 4'd6;
    localparam op_class_t CLS_STORE     = 4'd7;
    localparam op_class_t CLS_ALU_IMM   = 4'd8;
    localparam op_class_t CLS_SHIFT_IMM = 4'd9;
    localparam op_class_t CLS_ALU_REG   = 4'd10;
    localparam op_class_t CLS_FENCE     = 4'd11;
    localparam op_class_t CLS_ECALL     = 4'd12;
    localparam op_class_t CLS_EBREAK    = 4'd13;

    // the only accepted SYSTEM words
    localparam word_t INSN_ECALL  = 32'h0000_0073;
    localparam word_t INSN_EBREAK = 32'h0010_0073;

endpackage

/* rtl/rv_instr_classifier.sv */
// RV32I opcode classifier
module rv_instr_classifier
    import rv_decode_pkg::*;
(
    input  word_t     instr,
    output op_class_t cls,
    output imm_fmt_t  fmt,
    output logic      illegal,
    output logic      rd_used,
    output logic      rs1_used,
    output logic      rs2_used,
    output logic      funct7_used,
    output logic      shamt_used
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    // raw fields for the legality checks
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        // illegal until an opcode arm says otherwise
        cls         = CLS_ILLEGAL;
        fmt         = FMT_NONE;
        rd_used     = 1'b0;
        rs1_used    = 1'b0;
        rs2_used    = 1'b0;
        funct7_used = 1'b0;
        shamt_used  = 1'b0;

        case (opcode)
            OPC_LUI:
            begin
                cls     = CLS_LUI;
                fmt     = FMT_U;
                rd_used = 1'b1;
            end
            OPC_AUIPC:
            begin
                cls     = CLS_AUIPC;
                fmt     = FMT_U;
                rd_used = 1'b1;
            end
            OPC_JAL:
            begin
                cls     = CLS_JAL;
                fmt     = FMT_J;
                rd_used = 1'b1;
            end
            OPC_JALR:
            begin
                // only funct3 000 is defined
                if (funct3 == 3'b000)
                begin
                    cls      = CLS_JALR;
                    fmt      = FMT_I;
                    rd_used  = 1'b1;
                    rs1_used = 1'b1;
                end
            end
            OPC_BRANCH:
            begin
                // 010 and 011 are holes in the branch map
                if (funct3 != 3'b010 && funct3 != 3'b011)
                begin
                    cls      = CLS_BRANCH;
                    fmt      = FMT_B;
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                end
            end
            OPC_LOAD:
            begin
                // lb lh lw lbu lhu
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                begin
                    cls      = CLS_LOAD;
                    fmt      = FMT_I;
                    rd_used  = 1'b1;
                    rs1_used = 1'b1;
                end
            end
            OPC_STORE:
            begin
                // sb sh sw
                if (funct3 inside {3'b000, 3'b001, 3'b010})
                begin
                    cls      = CLS_STORE;
                    fmt      = FMT_S;
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                end
            end
            OPC_OP_IMM:
            begin
                if (funct3 == 3'b001 || funct3 == 3'b101)
                begin
                    // slli needs base funct7, srli/srai may use alt
                    if (funct7 == FUNCT7_BASE ||
                        (funct3 == 3'b101 && funct7 == FUNCT7_ALT))
                    begin
                        cls         = CLS_SHIFT_IMM;
                        rd_used     = 1'b1;
                        rs1_used    = 1'b1;
                        funct7_used = 1'b1;
                        shamt_used  = 1'b1;
                    end
                end
                else
                begin
                    cls      = CLS_ALU_IMM;
                    fmt      = FMT_I;
                    rd_used  = 1'b1;
                    rs1_used = 1'b1;
                end
            end
            OPC_OP:
            begin
                // alt funct7 only for sub and sra
                if (funct7 == FUNCT7_BASE ||
                    (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)))
                begin
                    cls         = CLS_ALU_REG;
                    rd_used     = 1'b1;
                    rs1_used    = 1'b1;
                    rs2_used    = 1'b1;
                    funct7_used = 1'b1;
                end
            end
            OPC_MISC_MEM:
            begin
                // fence ordering fields are ignored
                cls = CLS_FENCE;
            end
            OPC_SYSTEM:
            begin
                // whole word must match, no csr support
                if (instr == INSN_ECALL)
                    cls = CLS_ECALL;
                else if (instr == INSN_EBREAK)
                    cls = CLS_EBREAK;
            end
            default:
            begin
                cls = CLS_ILLEGAL;
            end
        endcase
    end

    assign illegal = (cls == CLS_ILLEGAL);

endmodule

/* rtl/rv_imm_gen.sv */
// RV32I immediate generator
module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  word_t instr,
    output word_t imm_i,
    output word_t imm_s,
    output word_t imm_b,
    output word_t imm_u,
    output word_t imm_j
);

    logic sign;

    // every format sign-extends from bit 31
    assign sign = instr[31];

    // I type, imm[11:0] straight from the top
    assign imm_i = {{20{sign}}, instr[31:20]};

    // S type, split around rd position
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

    // B type
    // bit 11 sits in instr[7], bit 0 implied zero
    assign imm_b = {
        {19{sign}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // U type, low 12 bits cleared
    assign imm_u = {instr[31:12], 12'b0};

    // J type
    // scrambled 20 bit offset, halfword aligned
    assign imm_j = {
        {11{sign}},
        instr[31],
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

endmodule

/* rtl/rv_decode_reg.sv */
// Decode output register
module rv_decode_reg
    import rv_decode_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     instr,
    input  op_class_t cls,
    input  imm_fmt_t  fmt,
    input  logic      illegal,
    input  logic      rd_used,
    input  logic      rs1_used,
    input  logic      rs2_used,
    input  logic      funct7_used,
    input  logic      shamt_used,
    input  word_t     imm_i,
    input  word_t     imm_s,
    input  word_t     imm_b,
    input  word_t     imm_u,
    input  word_t     imm_j,
    output logic      out_valid,
    output logic      out_illegal,
    output op_class_t out_cls,
    output reg_idx_t  out_rd,
    output reg_idx_t  out_rs1,
    output reg_idx_t  out_rs2,
    output funct3_t   out_funct3,
    output funct7_t   out_funct7,
    output shamt_t    out_shamt,
    output word_t     out_imm
);

    word_t    imm_sel;
    logic     funct3_used;
    reg_idx_t rd_next;
    reg_idx_t rs1_next;
    reg_idx_t rs2_next;
    funct3_t  funct3_next;
    funct7_t  funct7_next;
    shamt_t   shamt_next;

    // immediate mux by format
    always_comb
    begin
        case (fmt)
            FMT_I:   imm_sel = imm_i;
            FMT_S:   imm_sel = imm_s;
            FMT_B:   imm_sel = imm_b;
            FMT_U:   imm_sel = imm_u;
            FMT_J:   imm_sel = imm_j;
            default: imm_sel = '0;
        endcase
    end

    // funct3 carries meaning only for these classes
    always_comb
    begin
        case (cls)
            CLS_ILLEGAL, CLS_LUI, CLS_AUIPC, CLS_JAL,
            CLS_FENCE, CLS_ECALL, CLS_EBREAK:
                funct3_used = 1'b0;
            default:
                funct3_used = 1'b1;
        endcase
    end

    // unused fields forced to zero, nop style
    assign rd_next     = rd_used     ? instr[11:7]  : '0;
    assign rs1_next    = rs1_used    ? instr[19:15] : '0;
    assign rs2_next    = rs2_used    ? instr[24:20] : '0;
    assign funct3_next = funct3_used ? instr[14:12] : '0;
    assign funct7_next = funct7_used ? instr[31:25] : '0;
    // shamt shares bits with rs2
    assign shamt_next  = shamt_used  ? instr[24:20] : '0;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
            out_cls     <= CLS_ILLEGAL;
            out_rd      <= '0;
            out_rs1     <= '0;
            out_rs2     <= '0;
            out_funct3  <= '0;
            out_funct7  <= '0;
            out_shamt   <= '0;
            out_imm     <= '0;
        end
        else
        begin
            // single cycle strobe, no stall
            out_valid <= in_valid;
            // payload holds between strobes
            if (in_valid)
            begin
                out_illegal <= illegal;
                out_cls     <= cls;
                out_rd      <= rd_next;
                out_rs1     <= rs1_next;
                out_rs2     <= rs2_next;
                out_funct3  <= funct3_next;
                out_funct7  <= funct7_next;
                out_shamt   <= shamt_next;
                out_imm     <= imm_sel;
            end
        end
    end

endmodule

/* rtl/rv_decode_top.sv */
// RV32I decode stage top
module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     instr,
    output logic      out_valid,
    output logic      out_illegal,
    output op_class_t out_cls,
    output reg_idx_t  out_rd,
    output reg_idx_t  out_rs1,
    output reg_idx_t  out_rs2,
    output funct3_t   out_funct3,
    output funct7_t   out_funct7,
    output shamt_t    out_shamt,
    output word_t     out_imm
);

    // classifier results
    op_class_t cls;
    imm_fmt_t  fmt;
    logic      illegal;
    logic      rd_used;
    logic      rs1_used;
    logic      rs2_used;
    logic      funct7_used;
    logic      shamt_used;

    // immediate candidates
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // both decoders see the raw word in parallel
    rv_instr_classifier i_classifier (
        .instr       (instr),
        .cls         (cls),
        .fmt         (fmt),
        .illegal     (illegal),
        .rd_used     (rd_used),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .funct7_used (funct7_used),
        .shamt_used  (shamt_used)
    );

    rv_imm_gen i_imm_gen (
        .instr (instr),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j)
    );

    // select, zero and register
    rv_decode_reg i_decode_reg (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instr       (instr),
        .cls         (cls),
        .fmt         (fmt),
        .illegal     (illegal),
        .rd_used     (rd_used),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .funct7_used (funct7_used),
        .shamt_used  (shamt_used),
        .imm_i       (imm_i),
        .imm_s       (imm_s),
        .imm_b       (imm_b),
        .imm_u       (imm_u),
        .imm_j       (imm_j),
        .out_valid   (out_valid),
        .out_illegal (out_illegal),
        .out_cls     (out_cls),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_funct3  (out_funct3),
        .out_funct7  (out_funct7),
        .out_shamt   (out_shamt),
        .out_imm     (out_imm)
    );

endmodule

/* tests/rv_decode_sva.sv */
// Decode output assertions
module rv_decode_sva
    import rv_decode_pkg::*;
(
    input logic      clock,
    input logic      rst_n,
    input logic      in_valid,
    input logic      out_valid,
    input logic      out_illegal,
    input op_class_t out_cls,
    input reg_idx_t  out_rd,
    input reg_idx_t  out_rs1,
    input reg_idx_t  out_rs2,
    input funct3_t   out_funct3,
    input funct7_t   out_funct7,
    input shamt_t    out_shamt,
    input word_t     out_imm
);
    timeunit 1ns;
    timeprecision 1ps;

    // result strobe is the input strobe one cycle late
    assert property (@(posedge clock) disable iff (!rst_n) out_valid == $past(in_valid))
    else
        $error("out_valid does not follow in_valid by one cycle");

    // illegal result carries no fields
    assert property (@(posedge clock) disable iff (!rst_n)
        out_illegal |-> (out_cls == CLS_ILLEGAL && out_rd == '0 && out_rs1 == '0 &&
                         out_rs2 == '0 && out_funct3 == '0 && out_funct7 == '0 &&
                         out_shamt == '0 && out_imm == '0))
    else
        $error("illegal result with nonzero fields");

    // no result while in reset
    assert property (@(posedge clock) !rst_n |-> !out_valid)
    else
        $error("out_valid high during reset");

endmodule

bind rv_decode_top rv_decode_sva i_sva (.*);

/* tests/rv_decode_tb.sv */
// RV32I decode stage testbench
module rv_decode_tb
    import rv_decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 8;
    localparam logic [31:0] LFSR_SEED      = 32'h8b32e02c;
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

    logic      clock;
    logic      rst_n;
    logic      in_valid;
    word_t     instr;
    logic      out_valid;
    logic      out_illegal;
    op_class_t out_cls;
    reg_idx_t  out_rd;
    reg_idx_t  out_rs1;
    reg_idx_t  out_rs2;
    funct3_t   out_funct3;
    funct7_t   out_funct7;
    shamt_t    out_shamt;
    word_t     out_imm;

    int          errors;
    logic [31:0] lfsr_state;

    // expected result from the reference decode
    logic      exp_illegal;
    op_class_t exp_cls;
    reg_idx_t  exp_rd;
    reg_idx_t  exp_rs1;
    reg_idx_t  exp_rs2;
    funct3_t   exp_funct3;
    funct7_t   exp_funct7;
    shamt_t    exp_shamt;
    word_t     exp_imm;

    rv_decode_top i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instr       (instr),
        .out_valid   (out_valid),
        .out_illegal (out_illegal),
        .out_cls     (out_cls),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_funct3  (out_funct3),
        .out_funct7  (out_funct7),
        .out_shamt   (out_shamt),
        .out_imm     (out_imm)
    );

    // 40 ns period
    always
    begin
        #20;
        clock = ~clock;
    end

    // galois lfsr stepped once per bit
    function logic lfsr_step();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        return lsb;
    endfunction

    function word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    // random fields with fixed opcode and funct3
    function automatic word_t make_insn(opcode_t opc, funct3_t f3);
        word_t w;
        w = rand_bits(32);
        w[14:12] = f3;
        w[6:0] = opc;
        return w;
    endfunction

    function automatic word_t set_funct7(word_t w, funct7_t f7);
        word_t r;
        r = w;
        r[31:25] = f7;
        return r;
    endfunction

    // sign extend from an n bit value
    function automatic word_t sext(word_t v, int bits);
        word_t t;
        t = v << (32 - bits);
        return word_t'($signed(t) >>> (32 - bits));
    endfunction

    // reference decode straight from the isa tables
    function void ref_decode(word_t w);
        opcode_t opc;
        funct3_t f3;
        funct7_t f7;
        logic    use_rd;
        logic    use_rs1;
        logic    use_rs2;
        logic    use_f3;
        logic    use_f7;
        logic    use_sh;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        exp_cls = CLS_ILLEGAL;
        exp_imm = '0;
        {use_rd, use_rs1, use_rs2, use_f3, use_f7, use_sh} = '0;
        case (opc)
            OPC_LUI, OPC_AUIPC:
            begin
                exp_cls = (opc == OPC_LUI) ? CLS_LUI : CLS_AUIPC;
                exp_imm = {w[31:12], 12'h000};
                use_rd = 1'b1;
            end
            OPC_JAL:
            begin
                exp_cls = CLS_JAL;
                exp_imm = sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                use_rd = 1'b1;
            end
            OPC_JALR:
            begin
                if (f3 == 3'd0)
                begin
                    exp_cls = CLS_JALR;
                    exp_imm = sext({20'b0, w[31:20]}, 12);
                    {use_rd, use_rs1, use_f3} = 3'b111;
                end
            end
            OPC_LOAD:
            begin
                // lb lh lw lbu lhu only
                if (f3 != 3'd3 && f3 < 3'd6)
                begin
                    exp_cls = CLS_LOAD;
                    exp_imm = sext({20'b0, w[31:20]}, 12);
                    {use_rd, use_rs1, use_f3} = 3'b111;
                end
            end
            OPC_STORE:
            begin
                if (f3 < 3'd3)
                begin
                    exp_cls = CLS_STORE;
                    exp_imm = sext({20'b0, w[31:25], w[11:7]}, 12);
                    {use_rs1, use_rs2, use_f3} = 3'b111;
                end
            end
            OPC_BRANCH:
            begin
                if (f3 != 3'd2 && f3 != 3'd3)
                begin
                    exp_cls = CLS_BRANCH;
                    exp_imm = sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                    {use_rs1, use_rs2, use_f3} = 3'b111;
                end
            end
            OPC_OP_IMM:
            begin
                if (f3 == 3'd1 || f3 == 3'd5)
                begin
                    // shifts carry shamt and funct7 and no immediate
                    if (f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20))
                    begin
                        exp_cls = CLS_SHIFT_IMM;
                        {use_rd, use_rs1, use_f3, use_f7, use_sh} = 5'b11111;
                    end
                end
                else
                begin
                    exp_cls = CLS_ALU_IMM;
                    exp_imm = sext({20'b0, w[31:20]}, 12);
                    {use_rd, use_rs1, use_f3} = 3'b111;
                end
            end
            OPC_OP:
            begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                begin
                    exp_cls = CLS_ALU_REG;
                    {use_rd, use_rs1, use_rs2, use_f3, use_f7} = 5'b11111;
                end
            end
            OPC_MISC_MEM:
                exp_cls = CLS_FENCE;
            OPC_SYSTEM:
            begin
                if (w == INSN_ECALL)
                    exp_cls = CLS_ECALL;
                else if (w == INSN_EBREAK)
                    exp_cls = CLS_EBREAK;
            end
            default:
                exp_cls = CLS_ILLEGAL;
        endcase
        exp_illegal = (exp_cls == CLS_ILLEGAL);
        exp_rd = use_rd ? w[11:7] : '0;
        exp_rs1 = use_rs1 ? w[19:15] : '0;
        exp_rs2 = use_rs2 ? w[24:20] : '0;
        exp_funct3 = use_f3 ? f3 : '0;
        exp_funct7 = use_f7 ? f7 : '0;
        exp_shamt = use_sh ? w[24:20] : '0;
    endfunction

    task automatic check_field(string name, word_t got, word_t exp, word_t w);
        assert (got === exp)
        else
        begin
            $display("ERROR @%0t: %s is %h, expected %h (instr %h)",
                     $time, name, got, exp, w);
            errors++;
        end
    endtask

    task automatic check_outputs(word_t w, logic valid_exp);
        check_field("out_valid", word_t'(out_valid), word_t'(valid_exp), w);
        check_field("out_illegal", word_t'(out_illegal), word_t'(exp_illegal), w);
        check_field("out_cls", word_t'(out_cls), word_t'(exp_cls), w);
        check_field("out_rd", word_t'(out_rd), word_t'(exp_rd), w);
        check_field("out_rs1", word_t'(out_rs1), word_t'(exp_rs1), w);
        check_field("out_rs2", word_t'(out_rs2), word_t'(exp_rs2), w);
        check_field("out_funct3", word_t'(out_funct3), word_t'(exp_funct3), w);
        check_field("out_funct7", word_t'(out_funct7), word_t'(exp_funct7), w);
        check_field("out_shamt", word_t'(out_shamt), word_t'(exp_shamt), w);
        check_field("out_imm", out_imm, exp_imm, w);
    endtask

    // one strobe then wait for the result and check that it holds
    task automatic decode_one(word_t w);
        int waited;
        ref_decode(w);
        instr = w;
        in_valid = 1'b1;
        @(posedge clock);
        #2;
        in_valid = 1'b0;
        waited = 0;
        while (!out_valid && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clock);
            #2;
            waited++;
        end
        if (!out_valid)
        begin
            $display("timeout: no out_valid within %0d cycles for instr %h",
                     TIMEOUT_CYCLES, w);
            errors++;
        end
        else
        begin
            check_field("latency", word_t'(waited), '0, w);
            check_outputs(w, 1'b1);
            @(posedge clock);
            #2;
            // strobe drops while payload holds
            check_outputs(w, 1'b0);
        end
    endtask

    task automatic test_reset_state();
        exp_illegal = 1'b0;
        exp_cls = CLS_ILLEGAL;
        {exp_rd, exp_rs1, exp_rs2, exp_shamt} = '0;
        {exp_funct3, exp_funct7, exp_imm} = '0;
        check_outputs('0, 1'b0);
    endtask

    task automatic test_back_to_back();
        word_t burst [4];
        burst[0] = make_insn(OPC_LUI, funct3_t'(rand_bits(3)));
        burst[1] = make_insn(OPC_STORE, 3'd2);
        burst[2] = set_funct7(make_insn(OPC_OP, 3'd0), 7'h20);
        burst[3] = make_insn(OPC_BRANCH, 3'd1);
        // one result per strobe on the next cycle in order
        for (int i = 0; i < 4; i++)
        begin
            instr = burst[i];
            in_valid = 1'b1;
            @(posedge clock);
            #2;
            ref_decode(burst[i]);
            check_outputs(burst[i], 1'b1);
        end
        in_valid = 1'b0;
        @(posedge clock);
        #2;
        check_outputs(burst[3], 1'b0);
    endtask

    task automatic test_upper_jump();
        for (int i = 0; i < 4; i++)
        begin
            decode_one(make_insn(OPC_LUI, funct3_t'(rand_bits(3))));
            decode_one(make_insn(OPC_AUIPC, funct3_t'(rand_bits(3))));
            decode_one(make_insn(OPC_JAL, funct3_t'(rand_bits(3))));
        end
    endtask

    task automatic test_i_type();
        funct3_t load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        funct3_t alu_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        word_t   w;
        // sign bit both ways
        for (int s = 0; s < 2; s++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                w = make_insn(OPC_LOAD, load_f3[i]);
                w[31] = s[0];
                decode_one(w);
            end
            for (int i = 0; i < 6; i++)
            begin
                w = make_insn(OPC_OP_IMM, alu_f3[i]);
                w[31] = s[0];
                decode_one(w);
            end
            w = make_insn(OPC_JALR, 3'd0);
            w[31] = s[0];
            decode_one(w);
        end
        // slli srli srai
        decode_one(set_funct7(make_insn(OPC_OP_IMM, 3'd1), 7'h00));
        decode_one(set_funct7(make_insn(OPC_OP_IMM, 3'd5), 7'h00));
        decode_one(set_funct7(make_insn(OPC_OP_IMM, 3'd5), 7'h20));
    endtask

    task automatic test_s_b_r();
        funct3_t br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 0; i < 3; i++)
            decode_one(make_insn(OPC_STORE, funct3_t'(i)));
        for (int i = 0; i < 6; i++)
            decode_one(make_insn(OPC_BRANCH, br_f3[i]));
        for (int i = 0; i < 8; i++)
            decode_one(set_funct7(make_insn(OPC_OP, funct3_t'(i)), 7'h00));
        // sub and sra
        decode_one(set_funct7(make_insn(OPC_OP, 3'd0), 7'h20));
        decode_one(set_funct7(make_insn(OPC_OP, 3'd5), 7'h20));
    endtask

    task automatic expect_illegal(word_t w);
        decode_one(w);
        check_field("illegal flag", word_t'(out_illegal), 32'd1, w);
    endtask

    task automatic test_illegal();
        expect_illegal(make_insn(7'b1111111, 3'd0));
        expect_illegal(make_insn(OPC_JALR, 3'd3));
        expect_illegal(make_insn(OPC_BRANCH, 3'd2));
        expect_illegal(make_insn(OPC_STORE, 3'd3));
        expect_illegal(set_funct7(make_insn(OPC_OP, 3'd1), 7'h20));
        expect_illegal(set_funct7(make_insn(OPC_OP_IMM, 3'd5), 7'h10));
        // mret encoding is neither ecall nor ebreak
        expect_illegal(32'h3020_0073);
    endtask

    task automatic test_system_fence();
        decode_one(INSN_ECALL);
        check_field("ecall class", word_t'(out_cls), word_t'(CLS_ECALL), INSN_ECALL);
        decode_one(INSN_EBREAK);
        check_field("ebreak class", word_t'(out_cls), word_t'(CLS_EBREAK), INSN_EBREAK);
        // fence fields are random so that zeroing is visible
        decode_one(make_insn(OPC_MISC_MEM, funct3_t'(rand_bits(3))));
        check_field("fence class", word_t'(out_cls), word_t'(CLS_FENCE), instr);
    endtask

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        errors = 0;
        lfsr_state = LFSR_SEED;
        repeat (3) @(posedge clock);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_back_to_back();
        test_upper_jump();
        test_i_type();
        test_s_b_r();
        test_illegal();
        test_system_fence();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* rv_decode.f */
rtl/rv_decode_pkg.sv
rtl/rv_instr_classifier.sv
rtl/rv_imm_gen.sv
rtl/rv_decode_reg.sv
rtl/rv_decode_top.sv
tests/rv_decode_sva.sv
tests/rv_decode_tb.sv

/* Makefile */
# Verilator build and run for the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= rv_decode_tb
FILELIST  ?= rv_decode.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
